// File: wb_cache.f
cache_cfg_pkg.sv
cache_bus_pkg.sv
sp_ram.sv
tag_access.sv
data_access.sv
cache_ctrl.sv
wb_cache.sv
wb_cache_props.sv
tb_wb_cache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the wb_cache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_wb_cache \
    -f wb_cache.f \
    -o sim_wb_cache

./obj_dir/sim_wb_cache +verilator+error+limit+1000 | tee "$LOG"

if grep -q "TB FAILED" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi
echo "Simulation passed"

// File: tb_wb_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_cache;

    localparam int RESET_CYCLES = 8;
    localparam int N_DIRECTED = 16;
    localparam int N_RANDOM = 120;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 200 * (N_DIRECTED + N_RANDOM);

    typedef struct packed {
        logic        we;
        logic [15:0] adr;
        logic [3:0]  sel;
        logic [31:0] dat;
    } mem_op_t;

    logic                   clk;
    logic                   rst_n;
    cache_bus_pkg::wb_req_t core_req;
    cache_bus_pkg::wb_rsp_t core_rsp;
    cache_bus_pkg::wb_req_t mem_req;
    cache_bus_pkg::wb_rsp_t mem_rsp;

    integer     seed = 32'h5a68_4cb4;
    int         errors = 0;
    int         checks = 0;
    logic [7:0] mem_bytes [65536];
    logic [7:0] shadow [65536];
    mem_op_t    mem_log [$];

    // Expected tag state with two ways and a round-robin pointer per set
    logic [7:0] model_tag [16][2];
    logic       model_valid [16][2];
    int         model_rr [16];

    wb_cache wb_cache_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .core_req (core_req),
        .core_rsp (core_rsp),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [7:0] init_byte(input logic [15:0] a);
        return (a[7:0] + 8'h3c) ^ {a[11:8], a[15:12]};
    endfunction

    // Little-endian word with byte n at address + n
    function automatic logic [31:0] shadow_word(input logic [15:0] adr);
        logic [31:0] w;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = shadow[{adr[15:2], 2'(i)}];
        end
        return w;
    endfunction

    function automatic logic model_hit(input logic [15:0] adr);
        logic found;
        found = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (model_valid[adr[7:4]][w] && model_tag[adr[7:4]][w] == adr[15:8]) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // First invalid way, else the round-robin way; the pointer moves on every fill
    function automatic void model_fill(input logic [15:0] adr);
        int way;
        way = model_rr[adr[7:4]];
        for (int w = 1; w >= 0; w--) begin
            if (!model_valid[adr[7:4]][w]) begin
                way = w;
            end
        end
        model_valid[adr[7:4]][way] = 1'b1;
        model_tag[adr[7:4]][way] = adr[15:8];
        model_rr[adr[7:4]] = (model_rr[adr[7:4]] + 1) % 2;
    endfunction

    task automatic core_access(input logic we, input logic [15:0] adr, input logic [3:0] sel,
                               input logic [31:0] dat, output logic [31:0] rdata,
                               output int cycles);
        cache_bus_pkg::wb_req_t req;
        req = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we = we;
        req.adr = adr;
        req.sel = sel;
        req.dat = dat;
        mem_log.delete();
        @(posedge clk);
        core_req <= req;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!core_rsp.ack);
        rdata = core_rsp.dat;
        @(posedge clk);
        core_req <= '0;
    endtask

    task automatic check_read(input logic [15:0] adr);
        logic [31:0] got;
        logic [31:0] exp;
        logic [15:0] base;
        logic        exp_hit;
        int          cycles;
        exp = shadow_word(adr);
        exp_hit = model_hit(adr);
        base = {adr[15:4], 4'h0};
        core_access(1'b0, adr, 4'hf, 32'h0, got, cycles);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t: read %h returned %h, expected %h", $time, adr, got, exp);
        end
        checks++;
        if (exp_hit) begin
            assert (cycles == 2 && mem_log.size() == 0) else begin
                errors++;
                $display("Read of %h at %0t should hit, but took %0d cycles and %0d bus cycles",
                         adr, $time, cycles, mem_log.size());
            end
        end else begin
            assert (mem_log.size() == 4) else begin
                errors++;
                $display("Read miss of %h at %0t made %0d memory cycles instead of four",
                         adr, $time, mem_log.size());
            end
            for (int i = 0; i < 4 && i < mem_log.size(); i++) begin
                assert (!mem_log[i].we && mem_log[i].adr == base + 16'(4 * i)) else begin
                    errors++;
                    $display("Mismatch at %0t: fetch beat %0d used address %h, expected %h",
                             $time, i, mem_log[i].adr, base + 16'(4 * i));
                end
            end
            model_fill(adr);
        end
    endtask

    task automatic check_write(input logic [15:0] adr, input logic [3:0] sel,
                               input logic [31:0] dat);
        logic [31:0] unused_rdata;
        int          cycles;
        core_access(1'b1, adr, sel, dat, unused_rdata, cycles);
        checks++;
        assert (mem_log.size() == 1 && mem_log[0].we && mem_log[0].adr == adr
                && mem_log[0].sel == sel && mem_log[0].dat == dat) else begin
            errors++;
            $display("Mismatch at %0t: write %h sel %b did not pass through as one memory write",
                     $time, adr, sel);
        end
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                shadow[{adr[15:2], 2'(i)}] = dat[8*i +: 8];
            end
        end
    endtask

    // Memory slave that decides at the falling edge and answers after 0 to 3 wait cycles
    initial begin : memory_model
        int          wait_left;
        logic        busy;
        logic [15:0] a;
        logic [31:0] word;
        mem_op_t     op;
        busy = 1'b0;
        wait_left = 0;
        mem_rsp <= '0;
        forever begin
            @(negedge clk);
            if (mem_req.cyc && mem_req.stb && !mem_rsp.ack) begin
                if (!busy) begin
                    busy = 1'b1;
                    wait_left = $random(seed) & 3;
                end
                if (wait_left == 0) begin
                    busy = 1'b0;
                    for (int i = 0; i < 4; i++) begin
                        a = {mem_req.adr[15:2], 2'(i)};
                        if (mem_req.we && mem_req.sel[i]) begin
                            mem_bytes[a] = mem_req.dat[8*i +: 8];
                        end
                        word[8*i +: 8] = mem_bytes[a];
                    end
                    op.we = mem_req.we;
                    op.adr = mem_req.adr;
                    op.sel = mem_req.sel;
                    op.dat = mem_req.dat;
                    mem_log.push_back(op);
                    @(posedge clk);
                    mem_rsp.ack <= 1'b1;
                    mem_rsp.dat <= word;
                    @(posedge clk);
                    mem_rsp.ack <= 1'b0;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [15:0] adr;
        logic [3:0]  sel;
        rst_n <= 1'b0;
        core_req <= '0;
        for (int a = 0; a < 65536; a++) begin
            mem_bytes[16'(a)] = init_byte(16'(a));
            shadow[16'(a)] = init_byte(16'(a));
        end
        for (int s = 0; s < 16; s++) begin
            model_rr[s] = 0;
            model_valid[s][0] = 1'b0;
            model_valid[s][1] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        checks++;
        assert (!core_rsp.ack && !mem_rsp.ack && !mem_req.cyc) else begin
            errors++;
            $display("A bus was active at %0t right after reset", $time);
        end

        // One line fill, then every word of it as a hit
        check_read(16'h0104);
        for (int i = 0; i < 4; i++) begin
            check_read(16'h0100 + 16'(4 * i));
        end
        check_write(16'h0108, 4'b0101, 32'hdead_beef);
        check_read(16'h0108);
        // Write miss leaves the line out of the cache
        check_write(16'h2240, 4'b1100, 32'h1234_5678);
        check_read(16'h2244);
        check_read(16'h2240);
        // Three tags fighting over set 3
        check_read(16'h0030);
        check_read(16'h1034);
        check_read(16'h2038);
        check_read(16'h003c);
        check_read(16'h1030);
        check_read(16'h2030);

        // Four tags over four sets keep evictions and hits both frequent
        for (int n = 0; n < N_RANDOM; n++) begin
            r = $random(seed);
            adr = {6'd0, r[1:0], 2'd0, r[3:2], r[5:4], 2'd0};
            sel = (r[11:8] == 4'd0) ? 4'b0001 : r[11:8];
            if (r[7:6] == 2'b11) begin
                check_write(adr, sel, $random(seed));
            end else begin
                check_read(adr);
            end
        end

        repeat (4) @(posedge clk);
        $display("Summary: %0d checks, %0d mismatches, %0d bus assertion failures",
                 checks, errors, wb_cache_i.props_i.fail_count);
        if (errors == 0 && wb_cache_i.props_i.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: wb_cache_props.sv
`timescale 1ns/1ps
`default_nettype none

module wb_cache_props (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire cache_bus_pkg::wb_req_t core_req,
    input  wire cache_bus_pkg::wb_rsp_t core_rsp,
    input  wire cache_bus_pkg::wb_req_t mem_req,
    input  wire cache_bus_pkg::wb_rsp_t mem_rsp
);

    int fail_count = 0;

    core_ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n)
        core_rsp.ack |-> core_req.cyc && core_req.stb)
    else begin
        fail_count++;
        $error("core ack without an active core request");
    end

    mem_ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp.ack |-> mem_req.cyc && mem_req.stb)
    else begin
        fail_count++;
        $error("memory ack without an active memory request");
    end

    // A waiting memory request keeps every field
    mem_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.stb && !mem_rsp.ack |=> $stable(mem_req))
    else begin
        fail_count++;
        $error("memory request changed before its ack");
    end

    core_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        core_rsp.ack |=> !core_rsp.ack)
    else begin
        fail_count++;
        $error("core ack held longer than one cycle");
    end

    mem_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp.ack |=> !mem_rsp.ack)
    else begin
        fail_count++;
        $error("memory ack held longer than one cycle");
    end

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !mem_req.cyc && !mem_req.stb && !core_rsp.ack)
    else begin
        fail_count++;
        $error("bus active during reset");
    end

    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !mem_req.cyc && !mem_req.stb)
    else begin
        fail_count++;
        $error("memory request raised right after reset");
    end

endmodule

bind wb_cache wb_cache_props props_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .core_req (core_req),
    .core_rsp (core_rsp),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp)
);

`default_nettype wire

// File: wb_cache.sv
`timescale 1ns/1ps
`default_nettype none

module wb_cache (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire cache_bus_pkg::wb_req_t core_req,
    output cache_bus_pkg::wb_rsp_t      core_rsp,
    output cache_bus_pkg::wb_req_t      mem_req,
    input  wire cache_bus_pkg::wb_rsp_t mem_rsp
);

    logic                                   lookup;
    logic                                   tag_wr;
    logic                                   hit;
    logic [cache_cfg_pkg::NUM_WAYS-1:0]     hit_way;
    logic [cache_cfg_pkg::NUM_WAYS-1:0]     victim_way;
    logic                                   read;
    logic                                   write;
    logic                                   fill;
    logic [cache_cfg_pkg::WSEL_W-1:0]       wsel;
    logic [cache_cfg_pkg::WORD_BYTES-1:0]   byteen;
    logic [cache_cfg_pkg::WORD_W-1:0]       write_data;
    cache_bus_pkg::cache_line_t             fill_data;
    logic [cache_cfg_pkg::NUM_WAYS-1:0]     way_sel;
    logic [cache_cfg_pkg::WORD_W-1:0]       read_data;

    cache_ctrl ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .core_req   (core_req),
        .core_rsp   (core_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .lookup     (lookup),
        .tag_wr     (tag_wr),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .read       (read),
        .write      (write),
        .fill       (fill),
        .wsel       (wsel),
        .byteen     (byteen),
        .write_data (write_data),
        .fill_data  (fill_data),
        .way_sel    (way_sel),
        .read_data  (read_data)
    );

    // Tag fill uses the same way the controller selects for the data fill
    tag_access tag_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .lookup     (lookup),
        .addr       (core_req.adr),
        .tag_wr     (tag_wr),
        .wr_way     (way_sel),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    data_access data_i (
        .clk        (clk),
        .read       (read),
        .write      (write),
        .fill       (fill),
        .addr       (core_req.adr),
        .wsel       (wsel),
        .byteen     (byteen),
        .write_data (write_data),
        .fill_data  (fill_data),
        .way_sel    (way_sel),
        .read_data  (read_data)
    );

endmodule

`default_nettype wire

// File: cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire cache_bus_pkg::wb_req_t                 core_req,
    output cache_bus_pkg::wb_rsp_t                      core_rsp,
    output cache_bus_pkg::wb_req_t                      mem_req,
    input  wire cache_bus_pkg::wb_rsp_t                 mem_rsp,
    output logic                                        lookup,
    output logic                                        tag_wr,
    input  wire logic                                   hit,
    input  wire logic [cache_cfg_pkg::NUM_WAYS-1:0]     hit_way,
    input  wire logic [cache_cfg_pkg::NUM_WAYS-1:0]     victim_way,
    output logic                                        read,
    output logic                                        write,
    output logic                                        fill,
    output logic [cache_cfg_pkg::WSEL_W-1:0]            wsel,
    output logic [cache_cfg_pkg::WORD_BYTES-1:0]        byteen,
    output logic [cache_cfg_pkg::WORD_W-1:0]            write_data,
    output cache_bus_pkg::cache_line_t                  fill_data,
    output logic [cache_cfg_pkg::NUM_WAYS-1:0]          way_sel,
    input  wire logic [cache_cfg_pkg::WORD_W-1:0]       read_data
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_COMPARE,
        S_FETCH,
        S_FILL,
        S_RESPOND,
        S_WRITE
    } state_t;

    state_t                             state_q;
    state_t                             state_d;
    logic [cache_cfg_pkg::WSEL_W-1:0]   beat_q;
    logic [cache_cfg_pkg::NUM_WAYS-1:0] way_q;
    logic                               rsp_rdy_q;
    cache_bus_pkg::cache_line_t         line_buf;
    logic                               req_valid;
    logic                               last_beat;

    assign req_valid = core_req.cyc & core_req.stb;
    assign last_beat = (beat_q == cache_cfg_pkg::WSEL_W'(cache_cfg_pkg::WORDS_PER_LINE - 1));

    // The core holds its request until ack, so its fields feed the datapath directly
    assign wsel = core_req.adr[cache_cfg_pkg::BOFF_W +: cache_cfg_pkg::WSEL_W];
    assign byteen = core_req.sel;
    assign write_data = core_req.dat;
    assign fill_data = line_buf;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:    if (req_valid) state_d = core_req.we ? S_WRITE : S_COMPARE;
            S_COMPARE: state_d = hit ? S_IDLE : S_FETCH;
            S_FETCH:   if (mem_rsp.ack && last_beat) state_d = S_FILL;
            S_FILL:    state_d = S_RESPOND;
            S_RESPOND: if (rsp_rdy_q) state_d = S_IDLE;
            S_WRITE:   if (mem_rsp.ack) state_d = S_RESPOND;
            default:   state_d = S_IDLE;
        endcase
    end

    always_comb begin
        lookup = 1'b0;
        tag_wr = 1'b0;
        read = 1'b0;
        write = 1'b0;
        fill = 1'b0;
        way_sel = '0;
        case (state_q)
            S_IDLE: begin
                lookup = req_valid;
                read = req_valid;
            end
            S_COMPARE: way_sel = hit_way;
            S_FILL: begin
                tag_wr = 1'b1;
                fill = 1'b1;
                read = 1'b1;
                way_sel = way_q;
            end
            S_RESPOND: begin
                read = 1'b1;
                way_sel = way_q;
            end
            // The merged word is written again in every wait cycle
            S_WRITE: begin
                write = hit;
                way_sel = hit_way;
            end
            default: ;
        endcase
    end

    assign core_rsp.ack = ((state_q == S_COMPARE) && hit) || ((state_q == S_RESPOND) && rsp_rdy_q);
    assign core_rsp.dat = read_data;

    always_comb begin
        mem_req = '0;
        if (state_q == S_FETCH) begin
            mem_req.cyc = 1'b1;
            mem_req.stb = 1'b1;
            mem_req.adr = {core_req.adr[cache_cfg_pkg::ADDR_W-1:
                                        cache_cfg_pkg::BOFF_W + cache_cfg_pkg::WSEL_W],
                           beat_q, {cache_cfg_pkg::BOFF_W{1'b0}}};
            mem_req.sel = '1;
        end else if (state_q == S_WRITE) begin
            mem_req.cyc = 1'b1;
            mem_req.stb = 1'b1;
            mem_req.we = 1'b1;
            mem_req.adr = core_req.adr;
            mem_req.sel = core_req.sel;
            mem_req.dat = core_req.dat;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            beat_q <= '0;
            way_q <= '0;
            rsp_rdy_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == S_COMPARE && !hit) begin
                way_q <= victim_way;
                beat_q <= '0;
            end else if (state_q == S_FETCH && mem_rsp.ack) begin
                beat_q <= beat_q + 1'b1;
            end
            // After a fill the read-first RAM needs one extra cycle for the new line
            rsp_rdy_q <= (state_q == S_WRITE) || (state_q == S_RESPOND);
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_FETCH && mem_rsp.ack) begin
            line_buf.words[beat_q] <= mem_rsp.dat;
        end
    end

endmodule

`default_nettype wire

// File: data_access.sv
`timescale 1ns/1ps
`default_nettype none

module data_access (
    input  wire logic                                   clk,
    input  wire logic                                   read,
    input  wire logic                                   write,
    input  wire logic                                   fill,
    input  wire logic [cache_cfg_pkg::ADDR_W-1:0]       addr,
    input  wire logic [cache_cfg_pkg::WSEL_W-1:0]       wsel,
    input  wire logic [cache_cfg_pkg::WORD_BYTES-1:0]   byteen,
    input  wire logic [cache_cfg_pkg::WORD_W-1:0]       write_data,
    input  wire cache_bus_pkg::cache_line_t             fill_data,
    input  wire logic [cache_cfg_pkg::NUM_WAYS-1:0]     way_sel,
    output logic [cache_cfg_pkg::WORD_W-1:0]            read_data
);

    logic [cache_cfg_pkg::SET_W-1:0]        line_addr;
    cache_bus_pkg::cache_line_t             wdata;
    logic [cache_cfg_pkg::LINE_BYTES-1:0]   wren;
    logic [cache_cfg_pkg::WORDS_PER_LINE-1:0][cache_cfg_pkg::WORD_BYTES-1:0] word_en;
    cache_bus_pkg::cache_line_t             way_rdata [cache_cfg_pkg::NUM_WAYS];
    cache_bus_pkg::cache_line_t             rdata;
    logic [cache_cfg_pkg::WSEL_W-1:0]       wsel_q;

    assign line_addr = addr[cache_cfg_pkg::BOFF_W + cache_cfg_pkg::WSEL_W +: cache_cfg_pkg::SET_W];

    // A write touches only the bytes of one word, a fill the whole line
    always_comb begin
        word_en = '0;
        word_en[wsel] = byteen;
        if (write) begin
            wdata.words = {cache_cfg_pkg::WORDS_PER_LINE{write_data}};
            wren = word_en;
        end else begin
            wdata = fill_data;
            wren = {cache_cfg_pkg::LINE_BYTES{fill}};
        end
    end

    for (genvar w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin : g_way
        sp_ram #(
            .payload_t (cache_bus_pkg::cache_line_t),
            .DEPTH     (cache_cfg_pkg::NUM_SETS),
            .BYTEENW   (cache_cfg_pkg::LINE_BYTES)
        ) data_store (
            .clk   (clk),
            .addr  (line_addr),
            .wren  (wren & {cache_cfg_pkg::LINE_BYTES{way_sel[w]}}),
            .wdata (wdata),
            .rdata (way_rdata[w])
        );
    end

    // Word select follows the RAM by one cycle
    always_ff @(posedge clk) begin
        if (read) begin
            wsel_q <= wsel;
        end
    end

    // way_sel here is the hit or fill way in the cycle the line comes out
    always_comb begin
        rdata = '0;
        for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin
            if (way_sel[w]) begin
                rdata.words = rdata.words | way_rdata[w].words;
            end
        end
    end

    assign read_data = rdata.words[wsel_q];

endmodule

`default_nettype wire

// File: tag_access.sv
`timescale 1ns/1ps
`default_nettype none

module tag_access (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire logic                                   lookup,
    input  wire logic [cache_cfg_pkg::ADDR_W-1:0]       addr,
    input  wire logic                                   tag_wr,
    input  wire logic [cache_cfg_pkg::NUM_WAYS-1:0]     wr_way,
    output logic                                        hit,
    output logic [cache_cfg_pkg::NUM_WAYS-1:0]          hit_way,
    output logic [cache_cfg_pkg::NUM_WAYS-1:0]          victim_way
);

    logic [cache_cfg_pkg::SET_W-1:0]    set_in;
    logic [cache_cfg_pkg::SET_W-1:0]    set_q;
    logic [cache_cfg_pkg::SET_W-1:0]    ram_addr;
    logic [cache_cfg_pkg::TAG_W-1:0]    tag_in;
    logic [cache_cfg_pkg::TAG_W-1:0]    tag_q;
    logic [cache_cfg_pkg::NUM_WAYS-1:0] valid_q [cache_cfg_pkg::NUM_SETS];
    logic [cache_cfg_pkg::WAY_W-1:0]    rr_q [cache_cfg_pkg::NUM_SETS];
    cache_bus_pkg::tag_entry_t          wr_entry;
    cache_bus_pkg::tag_entry_t          rd_entry [cache_cfg_pkg::NUM_WAYS];

    assign set_in = addr[cache_cfg_pkg::BOFF_W + cache_cfg_pkg::WSEL_W +: cache_cfg_pkg::SET_W];
    assign tag_in = addr[cache_cfg_pkg::ADDR_W-1 -: cache_cfg_pkg::TAG_W];

    // Outside a lookup the RAMs keep reading the held set, so results stay put
    assign ram_addr = lookup ? set_in : set_q;
    assign wr_entry = '{valid: 1'b1, tag: tag_q};

    always_ff @(posedge clk) begin
        if (lookup) begin
            set_q <= set_in;
            tag_q <= tag_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < cache_cfg_pkg::NUM_SETS; s++) begin
                valid_q[s] <= '0;
                rr_q[s] <= '0;
            end
        end else if (tag_wr) begin
            valid_q[set_q] <= valid_q[set_q] | wr_way;
            rr_q[set_q] <= rr_q[set_q] + cache_cfg_pkg::WAY_W'(1);
        end
    end

    for (genvar w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin : g_way
        sp_ram #(
            .payload_t (cache_bus_pkg::tag_entry_t),
            .DEPTH     (cache_cfg_pkg::NUM_SETS),
            .BYTEENW   (1)
        ) tag_store (
            .clk   (clk),
            .addr  (ram_addr),
            .wren  (tag_wr & wr_way[w]),
            .wdata (wr_entry),
            .rdata (rd_entry[w])
        );

        assign hit_way[w] = valid_q[set_q][w] & rd_entry[w].valid
                          & (rd_entry[w].tag == tag_q);
    end

    assign hit = |hit_way;

    // Lowest invalid way wins, else the set's round-robin pointer
    always_comb begin
        victim_way = '0;
        victim_way[rr_q[set_q]] = 1'b1;
        for (int w = cache_cfg_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[set_q][w]) begin
                victim_way = '0;
                victim_way[w] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: sp_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sp_ram #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 16,
    parameter int  BYTEENW   = 1
) (
    input  wire logic                           clk,
    input  wire logic [$clog2(DEPTH)-1:0]       addr,
    input  wire logic [BYTEENW-1:0]             wren,
    input  wire payload_t                       wdata,
    output payload_t                            rdata
);

    localparam int DATAW = $bits(payload_t);
    localparam int LANE_W = DATAW / BYTEENW;

    logic [DATAW-1:0] mem [DEPTH];
    logic [DATAW-1:0] wbits;

    assign wbits = wdata;

    // Read-first: a write in the same cycle returns the old contents
    always_ff @(posedge clk) begin
        for (int i = 0; i < BYTEENW; i++) begin
            if (wren[i]) begin
                mem[addr][i*LANE_W +: LANE_W] <= wbits[i*LANE_W +: LANE_W];
            end
        end
        rdata <= payload_t'(mem[addr]);
    end

endmodule

`default_nettype wire

// File: cache_bus_pkg.sv
`default_nettype none

package cache_bus_pkg;

    // Wishbone classic request, master to slave
    typedef struct packed {
        logic                                   cyc;
        logic                                   stb;
        logic                                   we;
        logic [cache_cfg_pkg::ADDR_W-1:0]       adr;
        logic [cache_cfg_pkg::WORD_BYTES-1:0]   sel;
        logic [cache_cfg_pkg::WORD_W-1:0]       dat;
    } wb_req_t;

    // Wishbone classic response, slave to master
    typedef struct packed {
        logic                                   ack;
        logic [cache_cfg_pkg::WORD_W-1:0]       dat;
    } wb_rsp_t;

    typedef struct packed {
        logic                                   valid;
        logic [cache_cfg_pkg::TAG_W-1:0]        tag;
    } tag_entry_t;

    // Word 0 sits in the low bits, so byte lane n of the line is byte n of the line
    typedef struct packed {
        logic [cache_cfg_pkg::WORDS_PER_LINE-1:0][cache_cfg_pkg::WORD_W-1:0] words;
    } cache_line_t;

endpackage

`default_nettype wire

// File: cache_cfg_pkg.sv
`default_nettype none

package cache_cfg_pkg;

    // Byte address and data word
    localparam int ADDR_W = 16;
    localparam int WORD_W = 32;
    localparam int WORD_BYTES = 4;

    // Cache geometry
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_SETS = 16;
    localparam int NUM_WAYS = 2;

    // Derived address fields from low to high are byte offset, word select, set and tag
    localparam int BOFF_W = $clog2(WORD_BYTES);
    localparam int WSEL_W = $clog2(WORDS_PER_LINE);
    localparam int SET_W = $clog2(NUM_SETS);
    localparam int TAG_W = ADDR_W - SET_W - WSEL_W - BOFF_W;

    // Round-robin pointer width per set
    localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

    localparam int LINE_BYTES = WORDS_PER_LINE * WORD_BYTES;

endpackage

`default_nettype wire
